// File: fpsu_cfg.svh
////////////////////////////////////////
// SIMD execution unit configuration
// widths, bypass bus count and opcodes,
// included by the package and its users
////////////////////////////////////////
`ifndef FPSU_CFG_SVH
`define FPSU_CFG_SVH

// datapath geometry
`define FPSU_LANE_W  32
`define FPSU_LANES   2
`define FPSU_DATA_W  64
// data plus parity plus spare top bit
`define FPSU_BUS_W   66
`define FPSU_NUM_BUS 4
`define FPSU_OP_W    5

// integer and logic opcodes
`define FPSU_OP_ADD     5'd0
`define FPSU_OP_SUB     5'd1
`define FPSU_OP_AND     5'd2
`define FPSU_OP_OR      5'd3
`define FPSU_OP_XOR     5'd4

// single precision compares, low bits give the condition
`define FPSU_OP_FCMP_EQ 5'd8
`define FPSU_OP_FCMP_LT 5'd9
`define FPSU_OP_FCMP_LE 5'd10
`define FPSU_OP_FCMP_UN 5'd11

`endif

// File: fpsu_pkg.sv
////////////////////////////////////////
// shared types of the SIMD execution unit
// imported by every pipeline stage
////////////////////////////////////////
`default_nettype none

`include "fpsu_cfg.svh"

package fpsu_pkg;

  // one lane, integer or IEEE single
  typedef logic [`FPSU_LANE_W-1:0] lane_t;

  // lane 0 sits in the low half
  typedef logic [`FPSU_DATA_W-1:0] data_t;

  // bit 65 zero, bit 64 even parity, 63:0 data
  typedef logic [`FPSU_BUS_W-1:0] bus_word_t;

  // one bit per bypass bus
  typedef logic [`FPSU_NUM_BUS-1:0] fwd_sel_t;

  typedef logic [`FPSU_OP_W-1:0] op_t;

  // executing path
  typedef logic [1:0] op_class_t;

  // bit 0 operand parity error, bit 1 trapped invalid compare
  typedef logic [1:0] retire_t;

  localparam op_class_t class_int   = 2'd0;
  localparam op_class_t class_logic = 2'd1;
  localparam op_class_t class_cmp   = 2'd2;

  // condition field for the logic path
  localparam logic [1:0] logic_and = 2'd0;
  localparam logic [1:0] logic_or  = 2'd1;
  localparam logic [1:0] logic_xor = 2'd2;

endpackage

`default_nettype wire

// File: fpsu_operand_fwd.sv
////////////////////////////////////////
// operand side of the SIMD unit
// picks each operand from the issue port or a
// bypass bus, checks parity, registers stage 1
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "fpsu_cfg.svh"

module fpsu_operand_fwd import fpsu_pkg::*; (
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire logic      issue_valid,
  input  wire bus_word_t issue_a,
  input  wire bus_word_t issue_b,
  input  wire fwd_sel_t  fwd_now_a,
  input  wire fwd_sel_t  fwd_late_a,
  input  wire fwd_sel_t  fwd_now_b,
  input  wire fwd_sel_t  fwd_late_b,
  input  wire bus_word_t byp_bus_0,
  input  wire bus_word_t byp_bus_1,
  input  wire bus_word_t byp_bus_2,
  input  wire bus_word_t byp_bus_3,
  output data_t          s1_a,
  output data_t          s1_b,
  output logic           s1_valid,
  output logic           s1_err
);

  bus_word_t [`FPSU_NUM_BUS-1:0] byp_now;
  bus_word_t [`FPSU_NUM_BUS-1:0] byp_late;
  bus_word_t                     sel_a;
  bus_word_t                     sel_b;

  // at most one select bit is set, so later hits never collide
  function automatic bus_word_t pick_operand(
    input bus_word_t                     port_w,
    input fwd_sel_t                      now_sel,
    input fwd_sel_t                      late_sel,
    input bus_word_t [`FPSU_NUM_BUS-1:0] now_w,
    input bus_word_t [`FPSU_NUM_BUS-1:0] late_w
  );
    bus_word_t w;
    w = port_w;
    for (int k = 0; k < `FPSU_NUM_BUS; k++) begin
      if (now_sel[k]) w = now_w[k];
      if (late_sel[k]) w = late_w[k];
    end
    return w;
  endfunction

  assign byp_now = {byp_bus_3, byp_bus_2, byp_bus_1, byp_bus_0};

  // bus copies for late forwarding
  always_ff @(posedge clk) begin
    if (rst) begin
      byp_late <= '0;
    end else begin
      byp_late <= byp_now;
    end
  end

  assign sel_a = pick_operand(issue_a, fwd_now_a, fwd_late_a, byp_now, byp_late);
  assign sel_b = pick_operand(issue_b, fwd_now_b, fwd_late_b, byp_now, byp_late);

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s1_err   <= 1'b0;
    end else begin
      s1_valid <= issue_valid;
      // a good word xors to zero over all bits
      s1_err   <= (^sel_a) | (^sel_b);
    end
  end

  always_ff @(posedge clk) begin
    s1_a <= sel_a[`FPSU_DATA_W-1:0];
    s1_b <= sel_b[`FPSU_DATA_W-1:0];
  end

  a_fwd_onehot: assert property (@(posedge clk) disable iff (rst)
    issue_valid |-> $onehot0({fwd_now_a, fwd_late_a}) && $onehot0({fwd_now_b, fwd_late_b}));

endmodule

`default_nettype wire

// File: fpsu_op_decode.sv
////////////////////////////////////////
// opcode decode for the SIMD unit
// path, subtract and condition, in step
// with the stage-1 operands
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "fpsu_cfg.svh"

module fpsu_op_decode import fpsu_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic issue_valid,
  input  wire op_t  issue_op,
  output op_class_t s1_class,
  output logic      s1_sub,
  output logic [1:0] s1_cond
);

  op_class_t  dec_class;
  logic       dec_sub;
  logic [1:0] dec_cond;
  logic       dec_known;

  always_comb begin
    dec_class = class_int;
    dec_sub   = 1'b0;
    dec_cond  = 2'd0;
    dec_known = 1'b1;
    case (issue_op)
      `FPSU_OP_ADD: dec_class = class_int;
      `FPSU_OP_SUB: dec_sub = 1'b1;
      `FPSU_OP_AND: begin
        dec_class = class_logic;
        dec_cond  = logic_and;
      end
      `FPSU_OP_OR: begin
        dec_class = class_logic;
        dec_cond  = logic_or;
      end
      `FPSU_OP_XOR: begin
        dec_class = class_logic;
        dec_cond  = logic_xor;
      end
      // eq, lt, le, unordered
      `FPSU_OP_FCMP_EQ, `FPSU_OP_FCMP_LT, `FPSU_OP_FCMP_LE, `FPSU_OP_FCMP_UN: begin
        dec_class = class_cmp;
        dec_cond  = issue_op[1:0];
      end
      default: dec_known = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_class <= class_int;
      s1_sub   <= 1'b0;
      s1_cond  <= 2'd0;
    end else if (issue_valid) begin
      s1_class <= dec_class;
      s1_sub   <= dec_sub;
      s1_cond  <= dec_cond;
    end
  end

  a_op_known: assert property (@(posedge clk) disable iff (rst) issue_valid |-> dec_known);

endmodule

`default_nettype wire

// File: fpsu_simd_exec.sv
////////////////////////////////////////
// lane-wise execution of the SIMD unit
// integer add/sub, logic ops and single
// precision compares into stage 2
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "fpsu_cfg.svh"

module fpsu_simd_exec import fpsu_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       s1_valid,
  input  wire logic       s1_err,
  input  wire data_t      s1_a,
  input  wire data_t      s1_b,
  input  wire op_class_t  s1_class,
  input  wire logic       s1_sub,
  input  wire logic [1:0] s1_cond,
  input  wire logic       inv_trap_en,
  output data_t           s2_result,
  output logic            s2_valid,
  output logic            s2_err,
  output logic            s2_nan
);

  lane_t [`FPSU_LANES-1:0] lane_res;
  logic  [`FPSU_LANES-1:0] lane_nan;

  function automatic logic is_nan(input lane_t x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  // flags in condition order: {un, le, lt, eq}
  function automatic logic [3:0] fcmp_flags(input lane_t a, input lane_t b);
    logic un;
    logic zeros;
    logic eq;
    logic lt;
    un    = is_nan(a) | is_nan(b);
    zeros = (a[30:0] == 31'd0) && (b[30:0] == 31'd0);
    eq    = ~un & ((a == b) | zeros);
    if (un || zeros) begin
      lt = 1'b0;
    end else if (a[31] != b[31]) begin
      lt = a[31];
    end else if (a[31]) begin
      // both negative, larger magnitude is smaller
      lt = a[30:0] > b[30:0];
    end else begin
      lt = a[30:0] < b[30:0];
    end
    return {un, lt | eq, lt, eq};
  endfunction

  for (genvar i = 0; i < `FPSU_LANES; i++) begin : g_lane
    lane_t      la;
    lane_t      lb;
    lane_t      res;
    logic [3:0] cmp;

    assign la  = s1_a[i*`FPSU_LANE_W +: `FPSU_LANE_W];
    assign lb  = s1_b[i*`FPSU_LANE_W +: `FPSU_LANE_W];
    assign cmp = fcmp_flags(la, lb);

    always_comb begin
      case (s1_class)
        class_int: res = s1_sub ? la - lb : la + lb;
        class_logic: begin
          case (s1_cond)
            logic_and: res = la & lb;
            logic_or:  res = la | lb;
            default:   res = la ^ lb;
          endcase
        end
        default: res = {`FPSU_LANE_W{cmp[s1_cond]}};
      endcase
    end

    assign lane_res[i] = res;
    assign lane_nan[i] = cmp[3];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_valid <= 1'b0;
      s2_err   <= 1'b0;
      s2_nan   <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
      s2_err   <= s1_err;
      // invalid only reports under the trap
      s2_nan   <= (s1_class == class_cmp) & (|lane_nan) & inv_trap_en;
    end
  end

  always_ff @(posedge clk) begin
    s2_result <= lane_res;
  end

endmodule

`default_nettype wire

// File: fpsu_writeback.sv
////////////////////////////////////////
// result side of the SIMD unit
// builds the parity bus word and the
// retire code in the stage-3 register
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "fpsu_cfg.svh"

module fpsu_writeback import fpsu_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  s2_valid,
  input  wire logic  s2_err,
  input  wire logic  s2_nan,
  input  wire data_t s2_result,
  output logic       result_valid,
  output bus_word_t  result_bus,
  output logic       ret_valid,
  output retire_t    ret_code
);

  logic      wb_ok;
  bus_word_t wb_word;
  retire_t   wb_code;

  // a parity error drops the result but still retires
  assign wb_ok = s2_valid & ~s2_err;

  // zero top bit, even parity over the data
  assign wb_word = {1'b0, ^s2_result, s2_result};

  always_comb begin
    wb_code    = '0;
    wb_code[0] = s2_err;
    wb_code[1] = s2_nan;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
      ret_valid    <= 1'b0;
      ret_code     <= '0;
    end else begin
      result_valid <= wb_ok;
      ret_valid    <= s2_valid;
      ret_code     <= s2_valid ? wb_code : '0;
    end
  end

  // bus reads as zero when nothing valid is on it
  always_ff @(posedge clk) begin
    if (rst) begin
      result_bus <= '0;
    end else begin
      result_bus <= wb_ok ? wb_word : '0;
    end
  end

endmodule

`default_nettype wire

// File: fpsu_top.sv
////////////////////////////////////////
// two-lane SIMD execution unit top level
// three-stage pipeline, one issue per cycle
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "fpsu_cfg.svh"

module fpsu_top import fpsu_pkg::*; (
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire logic      issue_valid,
  input  wire op_t       issue_op,
  input  wire bus_word_t issue_a,
  input  wire bus_word_t issue_b,
  input  wire fwd_sel_t  fwd_now_a,
  input  wire fwd_sel_t  fwd_late_a,
  input  wire fwd_sel_t  fwd_now_b,
  input  wire fwd_sel_t  fwd_late_b,
  input  wire bus_word_t byp_bus_0,
  input  wire bus_word_t byp_bus_1,
  input  wire bus_word_t byp_bus_2,
  input  wire bus_word_t byp_bus_3,
  input  wire logic      inv_trap_en,
  output logic           result_valid,
  output bus_word_t      result_bus,
  output logic           ret_valid,
  output retire_t        ret_code
);

  // stage 1
  data_t      s1_a;
  data_t      s1_b;
  logic       s1_valid;
  logic       s1_err;
  op_class_t  s1_class;
  logic       s1_sub;
  logic [1:0] s1_cond;

  // stage 2
  data_t      s2_result;
  logic       s2_valid;
  logic       s2_err;
  logic       s2_nan;

  fpsu_operand_fwd i_fpsu_operand_fwd (
    .clk, .rst, .issue_valid,
    .issue_a, .issue_b,
    .fwd_now_a, .fwd_late_a, .fwd_now_b, .fwd_late_b,
    .byp_bus_0, .byp_bus_1, .byp_bus_2, .byp_bus_3,
    .s1_a, .s1_b, .s1_valid, .s1_err
  );

  fpsu_op_decode i_fpsu_op_decode (
    .clk, .rst, .issue_valid, .issue_op,
    .s1_class, .s1_sub, .s1_cond
  );

  fpsu_simd_exec i_fpsu_simd_exec (
    .clk, .rst, .s1_valid, .s1_err, .s1_a, .s1_b,
    .s1_class, .s1_sub, .s1_cond, .inv_trap_en,
    .s2_result, .s2_valid, .s2_err, .s2_nan
  );

  fpsu_writeback i_fpsu_writeback (
    .clk, .rst, .s2_valid, .s2_err, .s2_nan, .s2_result,
    .result_valid, .result_bus, .ret_valid, .ret_code
  );

endmodule

`default_nettype wire

// File: tb_fpsu.sv
////////////////////////////////////////
// self-checking testbench of the SIMD unit
// issues with forwarding, predicts bus word
// and retire code, checks 3-cycle latency
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "fpsu_cfg.svh"

module tb_fpsu import fpsu_pkg::*; ();

  // sources 0..3 now bus, 4..7 late bus, 8 issue port
  localparam int PORT_SRC    = 8;
  localparam int N_ARITH     = 40;
  localparam int N_LOGIC     = 30;
  localparam int N_FCMP      = 2 * 4 * 12 * 12;
  localparam int N_CHAIN     = 40;
  localparam int N_PARITY    = 24;
  localparam int N_SINGLE    = 3;
  localparam int CYCLE_LIMIT = N_ARITH + N_LOGIC + N_FCMP + N_CHAIN + N_PARITY
                               + N_SINGLE + 50;

  // zeros, ones, twos, infinities, NaNs and a denormal
  localparam logic [31:0] FVALS [12] = '{
    32'h0000_0000, 32'h8000_0000, 32'h3f80_0000, 32'hbf80_0000,
    32'h4000_0000, 32'hc000_0000, 32'h7f80_0000, 32'hff80_0000,
    32'h7fc0_0000, 32'h7f80_0001, 32'hffc0_0000, 32'h0000_0001};
  localparam op_t CMP_OPS [4] = '{`FPSU_OP_FCMP_EQ, `FPSU_OP_FCMP_LT,
                                  `FPSU_OP_FCMP_LE, `FPSU_OP_FCMP_UN};

  logic      clk;
  logic      rst;
  logic      issue_valid;
  op_t       issue_op;
  bus_word_t issue_a;
  bus_word_t issue_b;
  fwd_sel_t  fwd_now_a;
  fwd_sel_t  fwd_late_a;
  fwd_sel_t  fwd_now_b;
  fwd_sel_t  fwd_late_b;
  bus_word_t byp_bus_1;
  bus_word_t byp_bus_2;
  bus_word_t byp_bus_3;
  logic      inv_trap_en;
  logic      result_valid;
  bus_word_t result_bus;
  logic      ret_valid;
  retire_t   ret_code;

  integer      seed;
  int          cyc = 0;
  int          edge_no;
  int          errors;
  logic        trap_now;
  // bus words as the DUT sees them at the next edge, now and late
  bus_word_t   seen_w [0:3];
  bus_word_t   late_w [0:3];
  // predicted result_bus after each edge, modulo 8
  bus_word_t   model_bus [0:7];
  logic [67:0] exp_q [$];
  int          due_q [$];
  string       name_q [$];

  fpsu_top i_fpsu_top (
    .clk, .rst, .issue_valid, .issue_op, .issue_a, .issue_b,
    .fwd_now_a, .fwd_late_a, .fwd_now_b, .fwd_late_b,
    .byp_bus_0(result_bus), .byp_bus_1, .byp_bus_2, .byp_bus_3,
    .inv_trap_en, .result_valid, .result_bus, .ret_valid, .ret_code
  );

  always #4 clk = ~clk;

  function automatic bus_word_t make_word(input logic [63:0] d);
    return {1'b0, ^d, d};
  endfunction

  function automatic logic [63:0] rand_data();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic int rand_src();
    return $unsigned($random(seed)) % 9;
  endfunction

  function automatic fwd_sel_t bus_mask(input int src);
    if (src >= 0 && src < 4) return fwd_sel_t'(1) << src;
    return '0;
  endfunction

  function automatic bus_word_t resolve_src(input bus_word_t port_w, input int src);
    for (int j = 0; j < 4; j++) begin
      if (src == j) return seen_w[j];
      if (src == j + 4) return late_w[j];
    end
    return port_w;
  endfunction

  function automatic logic nan_single(input logic [31:0] x);
    return (x & 32'h7fff_ffff) > 32'h7f80_0000;
  endfunction

  // singles map onto unsigned keys that sort like the values
  function automatic logic fcmp_holds(input op_t op, input logic [31:0] x,
                                      input logic [31:0] y);
    logic [31:0] kx;
    logic [31:0] ky;
    logic        un;
    logic        zeros;
    logic        eq;
    logic        lt;
    un    = nan_single(x) | nan_single(y);
    zeros = ((x | y) & 32'h7fff_ffff) == 32'h0;
    kx    = x[31] ? ~x : (x | 32'h8000_0000);
    ky    = y[31] ? ~y : (y | 32'h8000_0000);
    eq    = !un && (zeros || x == y);
    lt    = !un && !zeros && (kx < ky);
    case (op)
      `FPSU_OP_FCMP_EQ: return eq;
      `FPSU_OP_FCMP_LT: return lt;
      `FPSU_OP_FCMP_LE: return lt | eq;
      default:          return un;
    endcase
  endfunction

  // expected {ret_code, result_bus} of one issue
  function automatic logic [67:0] fpsu_ref(input op_t op, input bus_word_t wa,
                                           input bus_word_t wb, input logic trap);
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] r;
    logic [63:0] d;
    logic        bad;
    logic        any_nan;
    retire_t     code;
    bad     = (^wa) | (^wb);
    any_nan = 1'b0;
    d       = '0;
    for (int l = 0; l < 2; l++) begin
      x = wa[32*l +: 32];
      y = wb[32*l +: 32];
      case (op)
        `FPSU_OP_ADD: r = x + y;
        `FPSU_OP_SUB: r = x - y;
        `FPSU_OP_AND: r = x & y;
        `FPSU_OP_OR:  r = x | y;
        `FPSU_OP_XOR: r = x ^ y;
        default:      r = fcmp_holds(op, x, y) ? 32'hffff_ffff : 32'h0;
      endcase
      any_nan = any_nan | nan_single(x) | nan_single(y);
      d[32*l +: 32] = r;
    end
    code = {(op >= `FPSU_OP_FCMP_EQ) & any_nan & trap, bad};
    if (bad) return {code, 66'd0};
    return {code, 1'b0, ^d, d};
  endfunction

  task automatic fail_run(input string why);
    errors = errors + 1;
    $display("ERROR %s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_val(input string name, input logic [67:0] expv,
                           input logic [67:0] act);
    if (act !== expv) begin
      errors = errors + 1;
      $display("CHECK FAILED %s expected %0h actual %0h", name, expv, act);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // one clock: predict the issue, then drive it for the next edge
  task automatic drive_step(input logic valid, input op_t op, input bus_word_t wa,
                            input bus_word_t wb, input int sa, input int sb,
                            input string name);
    logic [67:0] expv;
    @(posedge clk);
    edge_no = edge_no + 1;
    for (int j = 0; j < 4; j++) late_w[j] = rst ? '0 : seen_w[j];
    seen_w[0] = model_bus[edge_no % 8];
    for (int j = 1; j < 4; j++) seen_w[j] = make_word(rand_data());
    expv = fpsu_ref(op, resolve_src(wa, sa), resolve_src(wb, sb), trap_now);
    model_bus[(edge_no + 3) % 8] = valid ? expv[65:0] : '0;
    if (valid) begin
      exp_q.push_back(expv);
      due_q.push_back(edge_no + 3);
      name_q.push_back(name);
    end
    issue_valid <= valid;
    issue_op    <= op;
    issue_a     <= wa;
    issue_b     <= wb;
    fwd_now_a   <= bus_mask(sa);
    fwd_late_a  <= bus_mask(sa - 4);
    fwd_now_b   <= bus_mask(sb);
    fwd_late_b  <= bus_mask(sb - 4);
    byp_bus_1   <= seen_w[1];
    byp_bus_2   <= seen_w[2];
    byp_bus_3   <= seen_w[3];
    inv_trap_en <= trap_now;
  endtask

  task automatic idle_step();
    drive_step(1'b0, `FPSU_OP_ADD, '0, '0, PORT_SRC, PORT_SRC, "idle");
  endtask

  task automatic drain();
    while (exp_q.size() != 0) idle_step();
  endtask

  // trap only changes with nothing in flight
  task automatic set_trap(input logic t);
    drain();
    trap_now = t;
    idle_step();
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > CYCLE_LIMIT) fail_run("timeout, run exceeded its cycle limit");
  end

  always @(negedge clk) begin : compare_proc
    logic [67:0] expv;
    logic        exp_rv;
    int          due;
    string       nm;
    if (cyc >= 1) begin
      if (ret_valid) begin
        if (exp_q.size() == 0) begin
          fail_run("ret_valid rose with no operation in flight");
        end else begin
          expv   = exp_q.pop_front();
          due    = due_q.pop_front();
          nm     = name_q.pop_front();
          exp_rv = ~expv[66];
          check_val({nm, " retire cycle"}, 68'(due), 68'(cyc));
          check_val({nm, " ret_code"}, 68'(expv[67:66]), 68'(ret_code));
          check_val({nm, " result_valid"}, 68'(exp_rv), 68'(result_valid));
          check_val({nm, " result_bus"}, 68'(expv[65:0]), 68'(result_bus));
        end
      end else begin
        check_val("idle result_valid", 68'd0, 68'(result_valid));
        check_val("idle result_bus", 68'd0, 68'(result_bus));
        check_val("idle ret_code", 68'd0, 68'(ret_code));
        if (exp_q.size() != 0) begin
          if (due_q[0] <= cyc) fail_run("an issued operation did not retire on time");
        end
      end
    end
  end

  initial begin : main_seq
    logic [63:0] da;
    logic [63:0] db;
    bus_word_t   wa;
    bus_word_t   wb;
    op_t         op;
    int          sa;
    int          sb;
    seed        = 33890;
    clk         = 1'b0;
    rst         = 1'b1;
    issue_valid = 1'b0;
    issue_op    = `FPSU_OP_ADD;
    issue_a     = '0;
    issue_b     = '0;
    fwd_now_a   = '0;
    fwd_late_a  = '0;
    fwd_now_b   = '0;
    fwd_late_b  = '0;
    byp_bus_1   = '0;
    byp_bus_2   = '0;
    byp_bus_3   = '0;
    inv_trap_en = 1'b0;
    trap_now    = 1'b0;
    edge_no     = 0;
    errors      = 0;
    for (int j = 0; j < 4; j++) seen_w[j] = '0;
    for (int j = 0; j < 8; j++) model_bus[j] = '0;
    idle_step();
    idle_step();
    rst <= 1'b0;

    for (int n = 0; n < N_ARITH; n++) begin
      da = rand_data();
      db = rand_data();
      if (($random(seed) & 3) == 0) da[31:0] = 32'hffff_ffff;
      if (($random(seed) & 3) == 0) db[63:32] = 32'h8000_0001;
      op = ($random(seed) & 1) ? `FPSU_OP_SUB : `FPSU_OP_ADD;
      drive_step(1'b1, op, make_word(da), make_word(db), rand_src(), rand_src(),
                 "int_addsub");
    end

    for (int n = 0; n < N_LOGIC; n++) begin
      case ($unsigned($random(seed)) % 3)
        0:       op = `FPSU_OP_AND;
        1:       op = `FPSU_OP_OR;
        default: op = `FPSU_OP_XOR;
      endcase
      drive_step(1'b1, op, make_word(rand_data()), make_word(rand_data()),
                 rand_src(), rand_src(), "logic_ops");
    end

    for (int t = 0; t < 2; t++) begin
      set_trap(t[0]);
      for (int c = 0; c < 4; c++) begin
        for (int i = 0; i < 12; i++) begin
          for (int j = 0; j < 12; j++) begin
            drive_step(1'b1, CMP_OPS[c], make_word({FVALS[j], FVALS[i]}),
                       make_word({FVALS[i], FVALS[j]}), PORT_SRC, PORT_SRC, "fcmp");
          end
        end
      end
    end

    // three interleaved chains through bus 0
    for (int n = 0; n < N_CHAIN; n++) begin
      sa = ($random(seed) & 1) ? 4 : 0;
      case ($unsigned($random(seed)) % 3)
        0:       sb = 0;
        1:       sb = 4;
        default: sb = PORT_SRC;
      endcase
      op = ($random(seed) & 1) ? `FPSU_OP_XOR : `FPSU_OP_ADD;
      drive_step(1'b1, op, '0, make_word(rand_data()), sa, sb, "fwd_chain");
    end

    for (int n = 0; n < N_PARITY; n++) begin
      wa = make_word(rand_data());
      wb = make_word(rand_data());
      sa = PORT_SRC;
      sb = rand_src();
      if (n % 4 == 0) wa[64] = ~wa[64];
      if (n % 4 == 1) begin
        wb[64] = ~wb[64];
        sa     = rand_src();
        sb     = PORT_SRC;
      end
      if (n % 4 == 2) wa[65] = 1'b1;
      if (n % 4 == 3) sa = rand_src();
      op = ($random(seed) & 1) ? `FPSU_OP_AND : `FPSU_OP_ADD;
      drive_step(1'b1, op, wa, wb, sa, sb, "parity_err");
    end

    drain();
    for (int n = 0; n < N_SINGLE; n++) begin
      drive_step(1'b1, `FPSU_OP_SUB, make_word(rand_data()), make_word(rand_data()),
                 PORT_SRC, PORT_SRC, "latency");
      repeat (4) idle_step();
    end

    drain();
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
fpsu_pkg.sv
fpsu_operand_fwd.sv
fpsu_op_decode.sv
fpsu_simd_exec.sv
fpsu_writeback.sv
fpsu_top.sv
tb_fpsu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the SIMD unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_fpsu -f src.f -o sim_fpsu

# a fatal check exits nonzero, so the log decides the result
./obj_dir/sim_fpsu > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
